// ==== source/split_params.svh ====
// ################################################
// unaligned access port parameters
// address width, memory size and memory wait
// ################################################

`ifndef SPLIT_PARAMS_SVH
`define SPLIT_PARAMS_SVH

// width of the byte address
`define ADDR_W 12

// whole memory in bytes, a multiple of the 16-byte line
`define MEM_BYTES (1 << `ADDR_W)

// wait cycles before the line memory acknowledges, 0 to 7
`define STORE_WAIT 2

`endif

// ==== source/mem_access_pkg.sv ====
// ################################################
// core-side access types
// request, part and split plan of an access
// ################################################

`include "split_params.svh"

package mem_access_pkg;

  typedef logic [`ADDR_W-1:0] byte_addr_t;  // byte address
  typedef logic [63:0]        data_t;       // little-endian data word
  typedef logic [2:0]         byte_cnt_t;   // n means n+1 bytes
  typedef logic [3:0]         part_cnt_t;   // byte count 1 to 8

  // access as presented by the requester
  typedef struct packed {
    byte_addr_t addr;
    data_t      wdata;
    byte_cnt_t  size;
    logic       write;
  } access_req_t;

  // one access contained inside a single line
  typedef struct packed {
    byte_addr_t addr;
    byte_cnt_t  size;
    data_t      wdata;   // own bytes at byte 0
    logic       write;
  } part_t;

  typedef struct packed {
    part_t     first;
    part_t     second;
    logic      need_second;  // access crosses a line
    part_cnt_t first_cnt;    // bytes in first part
  } split_plan_t;

endpackage

// ==== source/line_store_pkg.sv ====
// ################################################
// line memory port types
// line request and sequencer state
// ################################################

`include "split_params.svh"

package line_store_pkg;

  typedef logic [`ADDR_W-5:0] line_idx_t;  // line number
  typedef logic [3:0]         line_off_t;  // byte inside a line

  // one access inside a line
  typedef struct packed {
    line_idx_t                 idx;
    line_off_t                 off;
    mem_access_pkg::byte_cnt_t size;
    mem_access_pkg::data_t     data;   // write bytes at byte 0
    logic                      write;
  } line_req_t;

  // sequencer driving the port above
  typedef enum logic [1:0] {
    IDLE,
    FIRST,
    SECOND,
    HOLD
  } seq_state_t;

endpackage

// ==== source/split_decode.sv ====
// ################################################
// split decode
// finds whether an access crosses a 16-byte line
// and describes the one or two line parts
// ################################################

module split_decode (
  input  mem_access_pkg::access_req_t i_access,
  output mem_access_pkg::split_plan_t o_plan
);

  import mem_access_pkg::*;

  logic [4:0] off_ext;       // offset in line
  logic [4:0] size_ext;      // size minus one
  logic [4:0] end_pos;       // offset of last byte
  logic [4:0] first_sz_ext;
  logic [4:0] second_sz_ext;
  logic       crosses;
  part_cnt_t  first_cnt;
  byte_addr_t second_addr;

  assign off_ext  = {1'b0, i_access.addr[3:0]};
  assign size_ext = {2'b00, i_access.size};
  assign end_pos  = off_ext + size_ext;
  assign crosses  = end_pos > 5'd15;

  assign first_sz_ext  = crosses ? (5'd15 - off_ext) : size_ext;
  assign second_sz_ext = crosses ? (end_pos - 5'd16) : 5'd0;
  assign first_cnt     = first_sz_ext[3:0] + 4'd1;

  // start of next line, wraps to line 0 at the top
  assign second_addr = (i_access.addr | byte_addr_t'(15)) + 1'b1;

  always_comb begin
    o_plan.first.addr    = i_access.addr;
    o_plan.first.size    = first_sz_ext[2:0];
    o_plan.first.wdata   = i_access.wdata;
    o_plan.first.write   = i_access.write;

    o_plan.second.addr   = second_addr;
    o_plan.second.size   = second_sz_ext[2:0];
    o_plan.second.wdata  = i_access.wdata >> {first_cnt, 3'b000};  // drop first part bytes
    o_plan.second.write  = i_access.write;

    o_plan.need_second   = crosses;
    o_plan.first_cnt     = first_cnt;
  end

endmodule

// ==== source/split_sequencer.sv ====
// ################################################
// split sequencer
// issues one or two line accesses per request
// and reports each completed part
// ################################################

module split_sequencer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             i_req,
  input  mem_access_pkg::split_plan_t      i_plan,
  output logic                             o_store_req,
  output line_store_pkg::line_req_t        o_store_line,
  input  logic                             i_store_ack,
  output logic                             o_part_done,
  output logic                             o_part_last
);

  import mem_access_pkg::*;
  import line_store_pkg::*;

  seq_state_t state;
  part_t      cur_part;

  assign cur_part = (state == SECOND) ? i_plan.second : i_plan.first;

  // split the part address into line and offset
  always_comb begin
    o_store_line.idx   = line_idx_t'(cur_part.addr >> 4);
    o_store_line.off   = cur_part.addr[3:0];
    o_store_line.size  = cur_part.size;
    o_store_line.data  = cur_part.wdata;
    o_store_line.write = cur_part.write;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      o_store_req <= 1'b0;
      o_part_done <= 1'b0;
      o_part_last <= 1'b0;
    end else begin
      o_part_done <= 1'b0;  // single-cycle pulse
      case (state)
        IDLE: begin
          if (i_req) begin
            o_store_req <= 1'b1;
            state       <= FIRST;
          end
        end
        FIRST: begin
          if (o_store_req && i_store_ack) begin
            o_store_req <= 1'b0;
            o_part_done <= 1'b1;
            o_part_last <= !i_plan.need_second;
            state       <= i_plan.need_second ? SECOND : HOLD;
          end
        end
        SECOND: begin
          if (!o_store_req) begin
            o_store_req <= 1'b1;  // after one low cycle
          end else if (i_store_ack) begin
            o_store_req <= 1'b0;
            o_part_done <= 1'b1;
            o_part_last <= 1'b1;
            state       <= HOLD;
          end
        end
        HOLD: begin
          // a held request must not start twice
          if (!i_req) begin
            state <= IDLE;
          end
        end
        default: begin
          state       <= IDLE;
          o_store_req <= 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== source/merge_result.sv ====
// ################################################
// merge result
// joins the parts of a split read little-endian
// and pulses the acknowledge
// ################################################

module merge_result (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_part_done,
  input  logic                        i_part_last,
  input  mem_access_pkg::data_t       i_rdata,
  input  mem_access_pkg::part_cnt_t   i_first_cnt,
  output mem_access_pkg::data_t       o_rdata,
  output logic                        o_ack
);

  import mem_access_pkg::*;

  data_t first_data;  // low bytes of a split read
  logic  have_first;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack      <= 1'b0;
      have_first <= 1'b0;
    end else begin
      o_ack <= i_part_done && i_part_last;
      if (i_part_done) begin
        have_first <= !i_part_last;  // cleared by the last part
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_part_done) begin
      if (!i_part_last) begin
        first_data <= i_rdata;
      end else if (have_first) begin
        o_rdata <= first_data | (i_rdata << {i_first_cnt, 3'b000});  // second part above first
      end else begin
        o_rdata <= i_rdata;
      end
    end
  end

endmodule

// ==== source/line_store.sv ====
// ################################################
// line store
// byte memory in 16-byte lines, one access
// per request after a fixed wait
// ################################################

`include "split_params.svh"

module line_store (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_store_req,
  input  line_store_pkg::line_req_t   i_line,
  output logic                        o_store_ack,
  output mem_access_pkg::data_t       o_rdata
);

  import mem_access_pkg::*;
  import line_store_pkg::*;

  localparam int LINES = `MEM_BYTES / 16;

  logic [15:0][7:0] mem [0:LINES-1];
  logic [15:0][7:0] cur_line;
  logic [15:0][7:0] wr_bytes;  // write data placed in the line
  logic [15:0]      wr_be;
  data_t            rd_bytes;
  logic [2:0]       wait_cnt;
  logic             served;    // acked, waiting for request to drop
  logic             do_access;

  assign cur_line  = mem[i_line.idx];
  assign do_access = i_store_req && !served && (wait_cnt == 3'(`STORE_WAIT));

  // place write bytes and gather read bytes at the offset
  always_comb begin
    line_off_t pos;
    wr_bytes = '0;
    wr_be    = '0;
    rd_bytes = '0;
    for (int i = 0; i < 8; i++) begin
      pos = i_line.off + line_off_t'(i);
      if (i <= int'(i_line.size)) begin
        wr_be[pos]           = 1'b1;
        wr_bytes[pos]        = i_line.data[8*i +: 8];
        rd_bytes[8*i +: 8]   = cur_line[pos];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt    <= '0;
      served      <= 1'b0;
      o_store_ack <= 1'b0;
    end else begin
      o_store_ack <= do_access;
      if (do_access) begin
        served   <= 1'b1;
        wait_cnt <= '0;
      end else if (i_store_req && !served) begin
        wait_cnt <= wait_cnt + 3'd1;
      end
      if (!i_store_req) begin
        served <= 1'b0;  // ready for the next request
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_access) begin
      if (i_line.write) begin
        for (int j = 0; j < 16; j++) begin
          if (wr_be[j]) begin
            mem[i_line.idx][j] <= wr_bytes[j];
          end
        end
      end
      o_rdata <= i_line.write ? '0 : rd_bytes;  // writes return zero
    end
  end

endmodule

// ==== source/unaligned_access_top.sv ====
// ################################################
// unaligned access port
// splits line-crossing loads and stores into
// line accesses and merges the read data
// ################################################

module unaligned_access_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_req,
  input  mem_access_pkg::access_req_t i_access,
  output mem_access_pkg::data_t       o_rdata,
  output logic                        o_ack
);

  import mem_access_pkg::*;
  import line_store_pkg::*;

  split_plan_t plan;
  line_req_t   store_line;
  data_t       store_rdata;
  logic        store_req;
  logic        store_ack;
  logic        part_done;
  logic        part_last;

  split_decode u_decode (
    .i_access (i_access),
    .o_plan   (plan)
  );

  split_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .i_req        (i_req),
    .i_plan       (plan),
    .o_store_req  (store_req),
    .o_store_line (store_line),
    .i_store_ack  (store_ack),
    .o_part_done  (part_done),
    .o_part_last  (part_last)
  );

  merge_result u_result (
    .clk         (clk),
    .rst         (rst),
    .i_part_done (part_done),
    .i_part_last (part_last),
    .i_rdata     (store_rdata),
    .i_first_cnt (plan.first_cnt),
    .o_rdata     (o_rdata),
    .o_ack       (o_ack)
  );

  line_store u_store (
    .clk         (clk),
    .rst         (rst),
    .i_store_req (store_req),
    .i_line      (store_line),
    .o_store_ack (store_ack),
    .o_rdata     (store_rdata)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ################################################
// testbench clock and reset
// 40 ns clock, reset held for 4 cycles
// ################################################

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;  // released just after the edge
  end

endmodule

// ==== testbench/tb_unaligned_access.sv ====
// ################################################
// unaligned access port testbench
// random loads and stores checked against a
// byte-array model of the memory
// ################################################

`include "split_params.svh"

module tb_unaligned_access;

  timeunit 1ns;
  timeprecision 100ps;

  import mem_access_pkg::*;

  localparam int LINES = `MEM_BYTES / 16;

  logic        clk;
  logic        rst;
  logic        i_req;
  access_req_t i_access;
  data_t       o_rdata;
  logic        o_ack;

  logic [7:0] model [0:`MEM_BYTES-1];  // expected memory contents
  int         mismatches;
  int         tests_ok;
  int         tests_bad;
  logic       timed_out;               // a wait ran out, later results are void

  tb_clock_gen u_clock (
    .clk (clk),
    .rst (rst)
  );

  unaligned_access_top dut (
    .clk      (clk),
    .rst      (rst),
    .i_req    (i_req),
    .i_access (i_access),
    .o_rdata  (o_rdata),
    .o_ack    (o_ack)
  );

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (!timed_out && act !== exp) begin
      mismatches++;
      $display("FAIL at %0d ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic flag_timeout(input string why);
    $display("ERROR at %0d ns: %s", $time, why);
    timed_out = 1'b1;
  endtask

  function automatic access_req_t make_req(input byte_addr_t addr, input byte_cnt_t size,
                                           input data_t wdata, input logic write);
    access_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.size  = size;
    req.write = write;
    return req;
  endfunction

  // little-endian bytes from the model, upper bytes zero
  function automatic data_t model_read(input byte_addr_t addr, input byte_cnt_t size);
    data_t d;
    d = '0;
    for (int i = 0; i <= int'(size); i++) begin
      d[8*i +: 8] = model[(int'(addr) + i) % `MEM_BYTES];
    end
    return d;
  endfunction

  function automatic void model_write(input byte_addr_t addr, input byte_cnt_t size,
                                      input data_t wdata);
    for (int i = 0; i <= int'(size); i++) begin
      model[(int'(addr) + i) % `MEM_BYTES] = wdata[8*i +: 8];  // wraps past the top
    end
  endfunction

  // one request held until the acknowledge, then one idle cycle
  task automatic run_access(input access_req_t req, output data_t rdata);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    rdata  = '0;
    if (!timed_out) begin
      i_access = req;
      i_req    = 1'b1;
      while (!got && cycles < 100) begin
        @(posedge clk);
        #1;
        cycles++;
        got = o_ack;
      end
      if (!got) begin
        flag_timeout($sformatf("no acknowledge within 100 cycles for address %h", req.addr));
      end else begin
        rdata = o_rdata;
        i_req = 1'b0;
        @(posedge clk);
        #1;
        check_value("o_ack", 64'd0, {63'd0, o_ack});  // pulse is one cycle wide
      end
    end
  endtask

  task automatic write_access(input byte_addr_t addr, input byte_cnt_t size, input data_t wdata);
    data_t rd;
    run_access(make_req(addr, size, wdata, 1'b1), rd);
    check_value("o_rdata", 64'd0, rd);  // stores return zero
    model_write(addr, size, wdata);
  endtask

  task automatic read_check(input byte_addr_t addr, input byte_cnt_t size);
    data_t rd;
    run_access(make_req(addr, size, 64'd0, 1'b0), rd);
    check_value("o_rdata", model_read(addr, size), rd);
  endtask

  task automatic finish_test(input string name, input int start_err);
    if (mismatches == start_err && !timed_out) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else if (mismatches != start_err) begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, mismatches - start_err);
    end else begin
      tests_bad++;
      $display("test %s: stopped by a timeout", name);
    end
  endtask

  initial begin
    int          start_err;
    int          cycles;
    int          off;
    byte_addr_t  base;
    byte_cnt_t   sz;
    data_t       wd;
    data_t       rd;

    i_req      = 1'b0;
    i_access   = '0;
    mismatches = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    timed_out  = 1'b0;
    void'($urandom(23));
    for (int a = 0; a < `MEM_BYTES; a++) begin
      model[a] = 8'h00;
    end

    cycles = 0;
    while (rst !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (rst !== 1'b0) begin
      flag_timeout("reset was not released");
    end else begin
      // idle after reset, no acknowledge
      start_err = mismatches;
      for (int c = 0; c < 10; c++) begin
        @(posedge clk);
        #1;
        check_value("o_ack", 64'd0, {63'd0, o_ack});
      end
      finish_test("idle after reset", start_err);

      start_err = mismatches;
      for (int l = 0; l < LINES; l++) begin
        write_access(byte_addr_t'(l * 16), 3'd7, 64'd0);
        write_access(byte_addr_t'(l * 16 + 8), 3'd7, 64'd0);
      end
      finish_test("memory clear", start_err);

      // 1, 2, 4 and 8 bytes inside one line
      start_err = mismatches;
      for (int s = 0; s < 4; s++) begin
        sz = byte_cnt_t'((1 << s) - 1);
        for (int k = 0; k < 3; k++) begin
          if (k == 0) begin
            off = 0;
          end else if (k == 1) begin
            off = 16 - (1 << s);  // last byte at offset 15
          end else begin
            off = $urandom % (17 - (1 << s));
          end
          base = byte_addr_t'(($urandom % LINES) * 16 + off);
          wd   = {$urandom, $urandom};
          write_access(base, sz, wd);
          read_check(base, sz);
        end
      end
      finish_test("in-line accesses", start_err);

      start_err = mismatches;
      for (int o = 9; o < 16; o++) begin
        for (int n = 17 - o; n <= 8; n++) begin
          base = byte_addr_t'(($urandom % (LINES - 1)) * 16 + o);
          sz   = byte_cnt_t'(n - 1);
          wd   = {$urandom, $urandom};
          write_access(base, sz, wd);
          read_check(base, sz);
          read_check(base - 1'b1, 3'd0);            // byte below
          read_check(base + byte_addr_t'(n), 3'd0);  // byte above
        end
      end
      finish_test("line crossing", start_err);

      // last line offset 12, spills into line 0
      start_err = mismatches;
      base = byte_addr_t'(`MEM_BYTES - 4);
      wd   = {$urandom, $urandom};
      write_access(base, 3'd7, wd);
      read_check(base, 3'd7);
      run_access(make_req('0, 3'd3, 64'd0, 1'b0), rd);
      check_value("o_rdata", {32'd0, wd[63:32]}, rd);
      finish_test("wrap to line 0", start_err);

      start_err = mismatches;
      for (int t = 0; t < 300; t++) begin
        base = byte_addr_t'($urandom % `MEM_BYTES);
        sz   = byte_cnt_t'($urandom % 8);
        wd   = {$urandom, $urandom};
        if ($urandom % 2) begin
          write_access(base, sz, wd);
        end else begin
          read_check(base, sz);
        end
      end
      finish_test("random mix", start_err);
    end

    $display("tests passed %0d, failed %0d, mismatches %0d", tests_ok, tests_bad, mismatches);
    if (mismatches == 0 && tests_bad == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+source
source/mem_access_pkg.sv
source/line_store_pkg.sv
source/split_decode.sv
source/split_sequencer.sv
source/merge_result.sv
source/line_store.sv
source/unaligned_access_top.sv
testbench/tb_clock_gen.sv
testbench/tb_unaligned_access.sv
